// ==== hw/fifo_pkg.sv ====
package fifo_pkg;

        ////////////////////////////////////////////////////////////////////
        // Sizes
        ////////////////////////////////////////////////////////////////////

        // Width of one FIFO byte and of the Wishbone data bus
        localparam int data_width = 8;
        // RAM address and pointer width
        localparam int addr_width = 4;
        // RAM entries of which one always stays free
        localparam int depth = 2 ** addr_width;

        ////////////////////////////////////////////////////////////////////
        // Register map and status word
        ////////////////////////////////////////////////////////////////////

        // Write pushes and read pops
        localparam logic reg_data = 1'b0;
        // Read returns status and clears sticky flags
        localparam logic reg_status = 1'b1;

        // Status bit positions in the read word
        localparam int status_empty = 0;
        localparam int status_full = 1;
        localparam int status_overflow = 2;
        localparam int status_underflow = 3;

        // Controller states where bit 3 marks a push and bit 2 a combined step
        typedef enum logic [3:0] {
                idle         = 4'b0000,
                pop          = 4'b0001,
                push_write   = 4'b1000,
                push_advance = 4'b1001,
                both_write   = 4'b1100,
                both_advance = 4'b1101
        } ctrl_state_t;

endpackage

// ==== hw/fifo_if.sv ====
// Request channel between the bus slave and the FIFO controller
interface fifo_if;

        // Single-cycle requests, only while busy is low
        logic push;
        logic pop;
        // Byte to be pushed
        logic [fifo_pkg::data_width-1:0] wdata;
        // Current head byte
        logic [fifo_pkg::data_width-1:0] rdata;
        // Flags from the pointers
        logic empty;
        logic full;
        // High in any state but idle
        logic busy;

        modport slave (
                output push, pop, wdata,
                input  rdata, empty, full, busy
        );

        modport ctrl (
                input  push, pop, wdata,
                output rdata, empty, full, busy
        );

endinterface

// Memory channel between the controller and the byte RAM
interface ram_if;

        // Write port, rear pointer side
        logic we;
        logic [fifo_pkg::addr_width-1:0] waddr;
        logic [fifo_pkg::data_width-1:0] wdata;
        // Read port, front pointer side
        logic [fifo_pkg::addr_width-1:0] raddr;
        logic [fifo_pkg::data_width-1:0] rdata;

        modport ctrl (
                output we, waddr, wdata, raddr,
                input  rdata
        );

        modport ram (
                input  we, waddr, wdata, raddr,
                output rdata
        );

endinterface

// ==== hw/dual_port_ram.sv ====
module dual_port_ram (
        input logic clock,
        ram_if.ram  bus
);

        //////////////////////////////////////////////////////////////////////
        // Storage
        //////////////////////////////////////////////////////////////////////

        // 16 x 8 array, contents undefined after reset
        logic [fifo_pkg::data_width-1:0] mem [fifo_pkg::depth];

        //////////////////////////////////////////////////////////////////////
        // Write port
        //////////////////////////////////////////////////////////////////////

        // Synchronous write at the rear slot
        always_ff @(posedge clock) begin
                if (bus.we) begin
                        mem[bus.waddr] <= bus.wdata;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Read port
        //////////////////////////////////////////////////////////////////////

        // Asynchronous read, head byte visible without a clock
        assign bus.rdata = mem[bus.raddr];

endmodule

// ==== hw/fifo_ctrl.sv ====
module fifo_ctrl (
        input logic clock,
        input logic reset,
        fifo_if.ctrl host,
        ram_if.ctrl  mem
);

        //////////////////////////////////////////////////////////////////////
        // State and pointers
        //////////////////////////////////////////////////////////////////////

        fifo_pkg::ctrl_state_t state;
        fifo_pkg::ctrl_state_t state_next;

        // Front points at the head byte, rear at the next free slot
        logic [fifo_pkg::addr_width-1:0] front;
        logic [fifo_pkg::addr_width-1:0] rear;
        logic [fifo_pkg::addr_width-1:0] front_next;
        logic [fifo_pkg::addr_width-1:0] rear_next;

        // Byte held for the write state
        logic [fifo_pkg::data_width-1:0] wdata_q;

        // Step control
        logic writing;
        logic front_step;
        logic rear_step;

        //////////////////////////////////////////////////////////////////////
        // Flags
        //////////////////////////////////////////////////////////////////////

        // Incremented pointers wrap on their own at 16
        assign front_next = front + 1'b1;
        assign rear_next = rear + 1'b1;

        // Equal pointers mean nothing stored
        assign host.empty = (rear == front);
        // One slot kept free so full differs from empty
        assign host.full = (rear_next == front);
        // Any operation in flight
        assign host.busy = (state != fifo_pkg::idle);

        // Which states touch the RAM and the pointers
        assign writing = (state == fifo_pkg::push_write) ||
                         (state == fifo_pkg::both_write);
        assign front_step = (state == fifo_pkg::pop) ||
                            (state == fifo_pkg::both_write);
        assign rear_step = (state == fifo_pkg::push_advance) ||
                           (state == fifo_pkg::both_advance);

        //////////////////////////////////////////////////////////////////////
        // RAM hookup
        //////////////////////////////////////////////////////////////////////

        // Write lands at rear, read always shows front
        assign mem.we = writing;
        assign mem.waddr = rear;
        assign mem.wdata = wdata_q;
        assign mem.raddr = front;

        // Head byte straight through to the slave
        assign host.rdata = mem.rdata;

        //////////////////////////////////////////////////////////////////////
        // Registers
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= fifo_pkg::idle;
                        front <= '0;
                        rear <= '0;
                end else begin
                        state <= state_next;
                        if (front_step) begin
                                front <= front_next;
                        end
                        if (rear_step) begin
                                rear <= rear_next;
                        end
                end
        end

        // Capture the push byte as the request is taken
        always_ff @(posedge clock) begin
                if (state == fifo_pkg::idle && host.push) begin
                        wdata_q <= host.wdata;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Next state
        //////////////////////////////////////////////////////////////////////

        always_comb begin
                state_next = fifo_pkg::idle;
                case (state)
                        fifo_pkg::idle: begin
                                // Combined path first, then single ops
                                if (host.pop && !host.empty && host.push && !host.full) begin
                                        state_next = fifo_pkg::both_write;
                                end else if (host.pop && !host.empty) begin
                                        state_next = fifo_pkg::pop;
                                end else if (host.push && !host.full) begin
                                        state_next = fifo_pkg::push_write;
                                end
                        end
                        // Pop is a single step
                        fifo_pkg::pop: state_next = fifo_pkg::idle;
                        // Push writes, then moves rear
                        fifo_pkg::push_write: state_next = fifo_pkg::push_advance;
                        fifo_pkg::push_advance: state_next = fifo_pkg::idle;
                        // Combined, front moves during the write step
                        fifo_pkg::both_write: state_next = fifo_pkg::both_advance;
                        fifo_pkg::both_advance: state_next = fifo_pkg::idle;
                        default: state_next = fifo_pkg::idle;
                endcase
        end

endmodule

// ==== hw/wb_fifo_slave.sv ====
module wb_fifo_slave (
        input  logic clock,
        input  logic reset,
        input  logic cyc,
        input  logic stb,
        input  logic we,
        input  logic adr,
        input  logic [fifo_pkg::data_width-1:0] dat_w,
        output logic [fifo_pkg::data_width-1:0] dat_r,
        output logic ack,
        fifo_if.slave fifo
);

        //////////////////////////////////////////////////////////////////////
        // Sequencer
        //////////////////////////////////////////////////////////////////////

        typedef enum logic [1:0] {
                phase_idle,
                phase_issue,
                phase_wait,
                phase_ack
        } phase_t;

        phase_t phase;

        // Pending request kind, 1 for push
        logic op_push;
        // Sticky error flags
        logic overflow;
        logic underflow;
        // Status word as read from reg_status
        logic [fifo_pkg::data_width-1:0] status_word;

        // New transfer seen
        logic start;

        assign start = cyc && stb;

        // Request lives only in the issue cycle
        assign fifo.push = (phase == phase_issue) && op_push;
        assign fifo.pop = (phase == phase_issue) && !op_push;
        // Master holds dat_w until ack
        assign fifo.wdata = dat_w;

        // Fixed-latency ack, or first cycle the controller is free
        assign ack = (phase == phase_ack) || (phase == phase_wait && !fifo.busy);

        always_comb begin
                status_word = '0;
                status_word[fifo_pkg::status_empty] = fifo.empty;
                status_word[fifo_pkg::status_full] = fifo.full;
                status_word[fifo_pkg::status_overflow] = overflow;
                status_word[fifo_pkg::status_underflow] = underflow;
        end

        //////////////////////////////////////////////////////////////////////
        // Control registers
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        phase <= phase_idle;
                        op_push <= 1'b0;
                        overflow <= 1'b0;
                        underflow <= 1'b0;
                end else begin
                        case (phase)
                                phase_idle: begin
                                        if (start) begin
                                                // Default is a plain one-cycle ack
                                                phase <= phase_ack;
                                                if (adr == fifo_pkg::reg_status) begin
                                                        // Reading status clears both flags
                                                        if (!we) begin
                                                                overflow <= 1'b0;
                                                                underflow <= 1'b0;
                                                        end
                                                end else if (we) begin
                                                        if (fifo.full) begin
                                                                overflow <= 1'b1;
                                                        end else begin
                                                                op_push <= 1'b1;
                                                                phase <= phase_issue;
                                                        end
                                                end else begin
                                                        if (fifo.empty) begin
                                                                underflow <= 1'b1;
                                                        end else begin
                                                                op_push <= 1'b0;
                                                                phase <= phase_issue;
                                                        end
                                                end
                                        end
                                end
                                phase_issue: phase <= phase_wait;
                                // Leave as soon as ack goes out
                                phase_wait: begin
                                        if (!fifo.busy) begin
                                                phase <= phase_idle;
                                        end
                                end
                                phase_ack: phase <= phase_idle;
                                default: phase <= phase_idle;
                        endcase
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Read data
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clock) begin
                if (phase == phase_idle && start && !we) begin
                        // Status snapshot before the clear, zero on underflow
                        if (adr == fifo_pkg::reg_status) begin
                                dat_r <= status_word;
                        end else if (fifo.empty) begin
                                dat_r <= '0;
                        end
                end else if (phase == phase_issue && !op_push) begin
                        // Head byte taken together with the pop
                        dat_r <= fifo.rdata;
                end
        end

endmodule

// ==== hw/wb_fifo_top.sv ====
module wb_fifo_top (
        input  logic clock,
        input  logic reset,
        input  logic cyc,
        input  logic stb,
        input  logic we,
        input  logic adr,
        input  logic [fifo_pkg::data_width-1:0] dat_w,
        output logic [fifo_pkg::data_width-1:0] dat_r,
        output logic ack
);

        //////////////////////////////////////////////////////////////////////
        // Internal channels
        //////////////////////////////////////////////////////////////////////

        // Slave to controller requests
        fifo_if host_bus ();
        // Controller to RAM
        ram_if ram_bus ();

        //////////////////////////////////////////////////////////////////////
        // Blocks
        //////////////////////////////////////////////////////////////////////

        // Wishbone register window
        wb_fifo_slave u_slave (
                .clock (clock),
                .reset (reset),
                .cyc   (cyc),
                .stb   (stb),
                .we    (we),
                .adr   (adr),
                .dat_w (dat_w),
                .dat_r (dat_r),
                .ack   (ack),
                .fifo  (host_bus)
        );

        // Pointers and push/pop FSM
        fifo_ctrl u_ctrl (
                .clock (clock),
                .reset (reset),
                .host  (host_bus),
                .mem   (ram_bus)
        );

        // Byte storage
        dual_port_ram u_ram (
                .clock (clock),
                .bus   (ram_bus)
        );

endmodule

// ==== verif/wb_fifo_props.sv ====
module wb_fifo_props (
        input logic clock,
        input logic reset,
        input logic push,
        input logic pop,
        input logic empty,
        input logic full,
        input logic busy,
        input fifo_pkg::ctrl_state_t state
);

        // Failed checks so far
        int fail_count = 0;

        //////////////////////////////////////////////////////////////////////
        // Request rules on the slave side
        //////////////////////////////////////////////////////////////////////

        // Controller comes out of reset idle
        idle_after_reset: assert property (@(posedge clock)
                $fell(reset) |-> (state == fifo_pkg::idle && !busy))
        else begin
                fail_count++;
                $error("controller not idle right after reset");
        end

        // No push into a full FIFO
        push_not_full: assert property (@(posedge clock) disable iff (reset)
                push |-> !full)
        else begin
                fail_count++;
                $error("push request while the FIFO is full");
        end

        // No pop from an empty FIFO
        pop_not_empty: assert property (@(posedge clock) disable iff (reset)
                pop |-> !empty)
        else begin
                fail_count++;
                $error("pop request while the FIFO is empty");
        end

        // Requests only while the FSM is idle
        request_not_busy: assert property (@(posedge clock) disable iff (reset)
                (push || pop) |-> !busy)
        else begin
                fail_count++;
                $error("request arrived while the controller was busy");
        end

endmodule

bind fifo_ctrl wb_fifo_props props (
        .clock (clock),
        .reset (reset),
        .push  (host.push),
        .pop   (host.pop),
        .empty (host.empty),
        .full  (host.full),
        .busy  (host.busy),
        .state (state)
);

// ==== verif/wb_fifo_checker.sv ====
module wb_fifo_checker (
        input  logic clock,
        input  logic reset,
        input  logic cyc,
        input  logic stb,
        input  logic we,
        input  logic ack,
        input  logic [fifo_pkg::data_width-1:0] dat_r,
        input  logic [fifo_pkg::data_width-1:0] expected,
        input  int   test_id,
        input  logic finished,
        output int   error_total
);

        // Running counts
        int current_test = 0;
        int test_reads = 0;
        int test_errors = 0;
        int tests_done = 0;
        int reads_total = 0;
        int errors = 0;
        logic reported = 1'b0;

        assign error_total = errors;

        // One line for the test just ended
        task automatic close_test();
                if (current_test != 0) begin
                        $display("test %0d %s: %0d reads checked, %0d mismatches",
                                 current_test, (test_errors == 0) ? "ok" : "failed",
                                 test_reads, test_errors);
                        tests_done++;
                end
                test_reads = 0;
                test_errors = 0;
        endtask

        //////////////////////////////////////////////////////////////////////
        // Bus watch
        //////////////////////////////////////////////////////////////////////

        always @(posedge clock) begin
                if (!reset && !reported) begin
                        // New test number means the last one is over
                        if (test_id != current_test) begin
                                close_test();
                                current_test = test_id;
                        end
                        // Read data valid in the ack cycle
                        if (cyc && stb && ack && !we) begin
                                test_reads++;
                                reads_total++;
                                if (dat_r !== expected) begin
                                        $display("error at %0t: dat_r is %02h, expected %02h",
                                                 $time, dat_r, expected);
                                        test_errors++;
                                        errors++;
                                end
                        end
                        if (finished) begin
                                close_test();
                                $display("totals: %0d tests, %0d reads checked, %0d mismatches",
                                         tests_done, reads_total, errors);
                                reported = 1'b1;
                        end
                end
        end

endmodule

// ==== verif/tb_wb_fifo.sv ====
module tb_wb_fifo;

        // One bus transfer with its expected read value
        typedef struct {
                int                              test;
                logic                            we;
                logic                            adr;
                logic [fifo_pkg::data_width-1:0] data;
                logic [fifo_pkg::data_width-1:0] expected;
                logic                            chain;
        } entry_t;

        logic clock;
        logic reset;
        logic cyc;
        logic stb;
        logic we;
        logic adr;
        logic [fifo_pkg::data_width-1:0] dat_w;
        logic [fifo_pkg::data_width-1:0] dat_r;
        logic ack;

        // Checker side channel
        logic [fifo_pkg::data_width-1:0] expected;
        int test_id;
        logic finished;
        int error_total;

        // Stimulus and the FIFO reference model
        entry_t stim [$];
        logic [fifo_pkg::data_width-1:0] model [$];
        logic model_overflow;
        logic model_underflow;
        logic [15:0] lfsr;
        int cycle_limit = 0;

        wb_fifo_top uut (
                .clock (clock),
                .reset (reset),
                .cyc   (cyc),
                .stb   (stb),
                .we    (we),
                .adr   (adr),
                .dat_w (dat_w),
                .dat_r (dat_r),
                .ack   (ack)
        );

        wb_fifo_checker bus_checker (
                .clock       (clock),
                .reset       (reset),
                .cyc         (cyc),
                .stb         (stb),
                .we          (we),
                .ack         (ack),
                .dat_r       (dat_r),
                .expected    (expected),
                .test_id     (test_id),
                .finished    (finished),
                .error_total (error_total)
        );

        //////////////////////////////////////////////////////////////////////
        // Random bytes
        //////////////////////////////////////////////////////////////////////

        // 16-bit Galois LFSR with taps 16 14 13 11
        function automatic logic [15:0] lfsr_next(input logic [15:0] value);
                if (value[0]) begin
                        return (value >> 1) ^ 16'hB400;
                end
                return value >> 1;
        endfunction

        // Eight steps per byte and one output bit per step
        task automatic random_byte(output logic [fifo_pkg::data_width-1:0] value);
                value = '0;
                for (int b = 0; b < 8; b++) begin
                        value = {value[6:0], lfsr[0]};
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Stimulus table built from the queue model
        //////////////////////////////////////////////////////////////////////

        task automatic add_entry(input int test, input logic is_write, input logic address,
                                 input logic [7:0] data, input logic [7:0] read_value,
                                 input logic chain);
                entry_t e;
                e.test = test;
                e.we = is_write;
                e.adr = address;
                e.data = data;
                e.expected = read_value;
                e.chain = chain;
                stim.push_back(e);
        endtask

        // Full FIFO drops the byte and sets overflow
        task automatic queue_write(input int test, input logic [7:0] value, input logic chain);
                if (model.size() < fifo_pkg::depth - 1) begin
                        model.push_back(value);
                end else begin
                        model_overflow = 1'b1;
                end
                add_entry(test, 1'b1, fifo_pkg::reg_data, value, 8'h00, chain);
        endtask

        // Empty FIFO reads zero and sets underflow
        task automatic queue_read(input int test, input logic chain);
                logic [7:0] value;
                value = '0;
                if (model.size() > 0) begin
                        value = model.pop_front();
                end else begin
                        model_underflow = 1'b1;
                end
                add_entry(test, 1'b0, fifo_pkg::reg_data, 8'h00, value, chain);
        endtask

        // Status snapshot before the sticky flags clear
        task automatic queue_status(input int test, input logic chain);
                logic [7:0] word;
                word = '0;
                word[fifo_pkg::status_empty] = (model.size() == 0);
                word[fifo_pkg::status_full] = (model.size() == fifo_pkg::depth - 1);
                word[fifo_pkg::status_overflow] = model_overflow;
                word[fifo_pkg::status_underflow] = model_underflow;
                model_overflow = 1'b0;
                model_underflow = 1'b0;
                add_entry(test, 1'b0, fifo_pkg::reg_status, 8'h00, word, chain);
        endtask

        task automatic build_stimulus();
                logic [7:0] value;
                // Status right after reset
                queue_status(1, 1'b0);
                // Five bytes in order
                for (int k = 0; k < 5; k++) begin
                        queue_write(2, 8'h10 + 8'(k), 1'b0);
                end
                for (int k = 0; k < 5; k++) begin
                        queue_read(2, 1'b0);
                end
                queue_status(2, 1'b0);
                // Fill plus one dropped write
                for (int k = 0; k < 16; k++) begin
                        queue_write(3, 8'h30 + 8'(k), 1'b0);
                end
                // Overflow shows once and then clears
                queue_status(3, 1'b0);
                queue_status(3, 1'b0);
                for (int k = 0; k < 15; k++) begin
                        queue_read(3, 1'b0);
                end
                // Read while empty
                queue_read(4, 1'b0);
                queue_status(4, 1'b0);
                queue_status(4, 1'b0);
                // Bursts of three writes and two reads wrap the pointers
                for (int k = 0; k < 40; k++) begin
                        random_byte(value);
                        queue_write(5, value, 1'b0);
                        if (k % 3 == 2) begin
                                queue_read(5, 1'b0);
                                queue_read(5, 1'b0);
                        end
                end
                while (model.size() > 0) begin
                        queue_read(5, 1'b0);
                end
                // Back to back with cyc held
                for (int k = 0; k < 4; k++) begin
                        queue_write(6, 8'hC0 + 8'(k), k != 0);
                end
                for (int k = 0; k < 4; k++) begin
                        queue_read(6, 1'b1);
                end
                queue_status(6, 1'b1);
        endtask

        //////////////////////////////////////////////////////////////////////
        // Clock, driver and timeout
        //////////////////////////////////////////////////////////////////////

        initial begin
                clock = 1'b0;
                forever #10 clock = ~clock;
        end

        task automatic drive_entry(input entry_t e);
                cyc <= 1'b1;
                stb <= 1'b1;
                we <= e.we;
                adr <= e.adr;
                dat_w <= e.data;
                expected <= e.expected;
                test_id <= e.test;
        endtask

        // Variable latency until ack
        task automatic wait_for_ack();
                @(posedge clock);
                while (!ack) begin
                        @(posedge clock);
                end
        endtask

        initial begin
                reset <= 1'b1;
                cyc <= 1'b0;
                stb <= 1'b0;
                we <= 1'b0;
                adr <= 1'b0;
                dat_w <= '0;
                expected <= '0;
                test_id <= 0;
                finished <= 1'b0;
                lfsr = 16'd34020;
                model_overflow = 1'b0;
                model_underflow = 1'b0;
                build_stimulus();
                cycle_limit = stim.size() * 6 + 20;
                repeat (4) @(posedge clock);
                reset <= 1'b0;
                @(posedge clock);
                for (int i = 0; i < stim.size(); i++) begin
                        drive_entry(stim[i]);
                        wait_for_ack();
                        // Idle gap unless the next transfer follows directly
                        if (i + 1 == stim.size() || !stim[i + 1].chain) begin
                                cyc <= 1'b0;
                                stb <= 1'b0;
                                @(posedge clock);
                        end
                end
                finished <= 1'b1;
                repeat (2) @(posedge clock);
                if (error_total == 0 && uut.u_ctrl.props.fail_count == 0) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

        initial begin
                int cycles;
                cycles = 0;
                wait (cycle_limit != 0);
                while (cycles < cycle_limit) begin
                        @(posedge clock);
                        cycles++;
                end
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Test failures found");
                $finish;
        end

endmodule

// ==== list.f ====
hw/fifo_pkg.sv
hw/fifo_if.sv
hw/dual_port_ram.sv
hw/fifo_ctrl.sv
hw/wb_fifo_slave.sv
hw/wb_fifo_top.sv
verif/wb_fifo_props.sv
verif/wb_fifo_checker.sv
verif/tb_wb_fifo.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the Wishbone FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_wb_fifo -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_wb_fifo" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
